/* sim.f */
+incdir+rtl
+incdir+tests
rtl/jtag_pkg.sv
rtl/jtag_intf.sv
rtl/credit_fifo.sv
rtl/tap_decode.sv
rtl/dr_execute.sv
rtl/capture_result.sv
rtl/jtag_debug_top.sv
tests/jtag_debug_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the JTAG debug bridge simulation with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module jtag_debug_tb \
	-f sim.f \
	-o jtag_debug_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/jtag_debug_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "^TEST PASSED$"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tests/jtag_tb_tasks.svh */
`ifndef JTAG_TB_TASKS_SVH
`define JTAG_TB_TASKS_SVH

// One TCK period with TDO sampled just before the rising edge
task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
	@(posedge clk);
	tck_i <= 1'b0;
	tms_i <= tms;
	tdi_i <= tdi;
	repeat (TCK_HALF) @(posedge clk);
	tdo = tdo_o;
	tck_i <= 1'b1;
	repeat (TCK_HALF - 1) @(posedge clk);
endtask

// From Run-Test-Idle back to Run-Test-Idle
task automatic shift_ir(input logic [3:0] ir, output logic [3:0] cap);
	logic unused_bit;
	tck_cycle(1'b1, 1'b0, unused_bit);
	tck_cycle(1'b1, 1'b0, unused_bit);
	tck_cycle(1'b0, 1'b0, unused_bit);
	tck_cycle(1'b0, 1'b0, unused_bit);
	for (int i = 0; i < 4; i++)
		tck_cycle(i == 3, ir[i], cap[i]);
	tck_cycle(1'b1, 1'b0, unused_bit);
	tck_cycle(1'b0, 1'b0, unused_bit);
endtask

task automatic shift_dr(input int n, input logic [31:0] din, output logic [31:0] dout);
	logic unused_bit;
	dout = '0;
	tck_cycle(1'b1, 1'b0, unused_bit);
	tck_cycle(1'b0, 1'b0, unused_bit);
	tck_cycle(1'b0, 1'b0, unused_bit);
	for (int i = 0; i < n; i++)
		tck_cycle(i == n - 1, din[i], dout[i]);
	tck_cycle(1'b1, 1'b0, unused_bit);
	tck_cycle(1'b0, 1'b0, unused_bit);
endtask

task automatic set_addr(input logic [3:0] addr);
	logic [3:0] cap;
	logic [31:0] got;
	shift_ir(`JTAG_IR_ADDR, cap);
	shift_dr(`JTAG_ADDR_W, 32'(addr), got);
	check("ADDR capture", got, 32'(model_addr));
	model_addr = addr;
endtask

// Queue occupancy decides whether the bridge keeps the write
task automatic write_data(input logic [15:0] data);
	logic [3:0] cap;
	logic [31:0] got;
	logic [15:0] old;
	old = shadow_model[model_addr];
	if (exp_writes.size() < `JTAG_CFG_CREDITS)
		exp_writes.push_back({model_addr, data});
	else
		drop_model = 1'b1;
	shadow_model[model_addr] = data;
	shift_ir(`JTAG_IR_DATA, cap);
	shift_dr(`JTAG_DATA_W, 32'(data), got);
	check("DATA capture", got, 32'(old));
endtask

task automatic read_status(output logic [31:0] got);
	logic [3:0] cap;
	logic [31:0] expect_word;
	logic found;
	found = stat_model.size() > 0;
	expect_word = {14'd0, drop_model, found, found ? stat_model.pop_front() : 16'd0};
	drop_model = 1'b0;
	shift_ir(`JTAG_IR_STATUS, cap);
	shift_dr(32, 32'd0, got);
	check("STATUS capture", got, expect_word);
	stat_found += int'(found);
	check("stat_credit_o pulses", 32'(stat_pulses), 32'(stat_found));
endtask

task automatic push_status(input logic [15:0] word);
	@(posedge clk);
	stat_valid_i <= 1'b1;
	stat_data_i <= word;
	@(posedge clk);
	stat_valid_i <= 1'b0;
	stat_pushed++;
	stat_model.push_back(word);
endtask

`endif

/* tests/jtag_debug_tb.sv */
`include "jtag_config.svh"

module jtag_debug_tb;
	localparam int TCK_HALF = 8;
	localparam int MAX_CYCLES = 200 * 64 * 2 * TCK_HALF + 20000;
	localparam int WRITES = 100;

	logic clk;
	logic reset_i;
	logic tck_i;
	logic tms_i;
	logic tdi_i;
	logic trst_n_i;
	logic tdo_o;
	logic cfg_valid_o;
	logic [`JTAG_ADDR_W-1:0] cfg_addr_o;
	logic [`JTAG_DATA_W-1:0] cfg_data_o;
	logic cfg_credit_i;
	logic stat_valid_i;
	logic [`JTAG_DATA_W-1:0] stat_data_i;
	logic stat_credit_o;

	logic [15:0] shadow_model [16];
	logic [19:0] exp_writes [$];
	logic [15:0] stat_model [$];
	logic drop_model;
	logic [3:0] model_addr;
	logic hold_credits;
	logic [19:0] seen_write;
	logic [31:0] word;
	logic [31:0] bypass_out;
	logic [3:0] cap;
	logic tdo_bit;
	int sent_count = 0;
	int returned_count = 0;
	int credit_delay;
	int stat_pushed = 0;
	int stat_pulses = 0;
	int stat_found = 0;
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int count;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("MISMATCH time %0t %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	`include "jtag_tb_tasks.svh"

	jtag_debug_top i_jtag_debug_top (
		.clk(clk),
		.reset_i(reset_i),
		.tck_i(tck_i),
		.tms_i(tms_i),
		.tdi_i(tdi_i),
		.trst_n_i(trst_n_i),
		.tdo_o(tdo_o),
		.cfg_valid_o(cfg_valid_o),
		.cfg_addr_o(cfg_addr_o),
		.cfg_data_o(cfg_data_o),
		.cfg_credit_i(cfg_credit_i),
		.stat_valid_i(stat_valid_i),
		.stat_data_i(stat_data_i),
		.stat_credit_o(stat_credit_o)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, run did not finish", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Core side of the config stream
	always @(posedge clk) begin
		if (!reset_i && cfg_valid_o) begin
			sent_count++;
			if (sent_count > `JTAG_CFG_CREDITS + returned_count) begin
				errors++;
				$display("Config write at %0t sent without a credit", $time);
			end
			if (exp_writes.size() == 0) begin
				errors++;
				$display("Config write at %0t that no update produced", $time);
			end else begin
				seen_write = exp_writes.pop_front();
				check("cfg_addr_o", 32'(cfg_addr_o), 32'(seen_write[19:16]));
				check("cfg_data_o", 32'(cfg_data_o), 32'(seen_write[15:0]));
			end
		end
	end

	always begin
		@(posedge clk);
		if (!reset_i && !hold_credits && sent_count > returned_count) begin
			credit_delay = $urandom_range(20, 0);
			repeat (credit_delay) @(posedge clk);
			cfg_credit_i <= 1'b1;
			@(posedge clk);
			cfg_credit_i <= 1'b0;
			returned_count++;
		end
	end

	always @(posedge clk) begin
		if (stat_credit_o)
			stat_pulses++;
	end

	initial begin
		void'($urandom(32'hf023_5c20));
		reset_i = 1'b1;
		tck_i = 1'b0;
		tms_i = 1'b1;
		tdi_i = 1'b0;
		trst_n_i = 1'b1;
		cfg_credit_i = 1'b0;
		stat_valid_i = 1'b0;
		stat_data_i = '0;
		hold_credits = 1'b0;
		drop_model = 1'b0;
		model_addr = '0;
		for (int i = 0; i < 16; i++)
			shadow_model[i] = '0;
		repeat (16) @(posedge clk);
		reset_i <= 1'b0;
		@(posedge clk);
		check("cfg_valid_o", 32'(cfg_valid_o), 32'd0);
		check("stat_credit_o", 32'(stat_credit_o), 32'd0);
		check("tdo_o", 32'(tdo_o), 32'd0);

		// Leave Test-Logic-Reset, read IDCODE and the IR capture pattern
		tck_cycle(1'b0, 1'b0, tdo_bit);
		shift_dr(32, 32'd0, word);
		check("IDCODE", word, `JTAG_IDCODE);
		shift_ir(`JTAG_IR_IDCODE, cap);
		check("IR capture", 32'(cap), 32'd1);

		// Read-back shifts the same value in, so it is a second write
		for (int i = 0; i < WRITES; i++) begin
			set_addr(4'($urandom_range(15, 0)));
			write_data(16'($urandom));
			write_data(shadow_model[model_addr]);
		end

		// Credits held back until the queue overflows
		while (exp_writes.size() != 0 || sent_count != returned_count)
			@(posedge clk);
		hold_credits = 1'b1;
		for (int i = 0; i < 2 * `JTAG_CFG_CREDITS + 2; i++)
			write_data(16'($urandom));
		read_status(word);
		check("sticky drop bit", 32'(word[17]), 32'd1);
		hold_credits = 1'b0;
		while (exp_writes.size() != 0 || sent_count != returned_count)
			@(posedge clk);
		read_status(word);
		check("sticky drop bit", 32'(word[17]), 32'd0);

		for (int round = 0; round < 8; round++) begin
			count = $urandom_range(`JTAG_STAT_DEPTH - stat_pushed + stat_pulses, 0);
			for (int i = 0; i < count; i++)
				push_status(16'($urandom));
			count = $urandom_range(3, 1);
			for (int i = 0; i < count; i++)
				read_status(word);
		end
		while (stat_model.size() != 0)
			read_status(word);
		read_status(word);

		// BYPASS and an undefined code both give a one-bit path
		for (int k = 0; k < 2; k++) begin
			shift_ir(k == 0 ? `JTAG_IR_BYPASS : 4'd9, cap);
			word = $urandom;
			shift_dr(16, word, bypass_out);
			check("bypass TDO", 32'(bypass_out[15:0]), 32'({word[14:0], 1'b0}));
		end
		for (int i = 0; i < 5; i++)
			tck_cycle(1'b1, 1'b0, tdo_bit);
		tck_cycle(1'b0, 1'b0, tdo_bit);
		shift_dr(32, 32'd0, word);
		check("IDCODE after reset", word, `JTAG_IDCODE);

		while (exp_writes.size() != 0)
			@(posedge clk);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end
endmodule

/* rtl/jtag_debug_top.sv */
`include "jtag_config.svh"

module jtag_debug_top (
	input logic clk,
	input logic reset_i,
	input logic tck_i,
	input logic tms_i,
	input logic tdi_i,
	input logic trst_n_i,
	output logic tdo_o,
	output logic cfg_valid_o,
	output logic [`JTAG_ADDR_W-1:0] cfg_addr_o,
	output logic [`JTAG_DATA_W-1:0] cfg_data_o,
	input logic cfg_credit_i,
	input logic stat_valid_i,
	input logic [`JTAG_DATA_W-1:0] stat_data_i,
	output logic stat_credit_o
);
	logic cfg_drop;

	tap_ctrl_if ctrl_if ();
	dr_data_if dr_if ();

	tap_decode i_tap_decode (
		.clk(clk),
		.reset_i(reset_i),
		.tck_i(tck_i),
		.tms_i(tms_i),
		.tdi_i(tdi_i),
		.trst_n_i(trst_n_i),
		.ctrl(ctrl_if.source)
	);

	// Config writes leave here
	dr_execute i_dr_execute (
		.clk(clk),
		.reset_i(reset_i),
		.ctrl(ctrl_if.sink),
		.dr(dr_if.execute),
		.cfg_valid_o(cfg_valid_o),
		.cfg_addr_o(cfg_addr_o),
		.cfg_data_o(cfg_data_o),
		.cfg_credit_i(cfg_credit_i),
		.drop_o(cfg_drop)
	);

	capture_result i_capture_result (
		.clk(clk),
		.reset_i(reset_i),
		.ctrl(ctrl_if.sink),
		.dr(dr_if.result),
		.drop_i(cfg_drop),
		.stat_valid_i(stat_valid_i),
		.stat_data_i(stat_data_i),
		.stat_credit_o(stat_credit_o),
		.tdo_o(tdo_o)
	);
endmodule

/* rtl/capture_result.sv */
`include "jtag_config.svh"

module capture_result (
	input logic clk,
	input logic reset_i,
	tap_ctrl_if.sink ctrl,
	dr_data_if.result dr,
	input logic drop_i,
	input logic stat_valid_i,
	input logic [`JTAG_DATA_W-1:0] stat_data_i,
	output logic stat_credit_o,
	output logic tdo_o
);
	logic [31:0] cap_next;
	logic [31:0] cap_word;
	logic cap_load;
	logic drop_sticky;
	logic stat_pop;
	logic stat_empty;
	jtag_pkg::status_word_t stat_head;

	assign stat_pop = ctrl.capture && (ctrl.instr == jtag_pkg::INSTR_STATUS);

	credit_fifo #(
		.payload_t(jtag_pkg::status_word_t),
		.DEPTH(`JTAG_STAT_DEPTH),
		.CREDITS(0)
	) i_stat_fifo (
		.clk(clk),
		.reset_i(reset_i),
		.push_i(stat_valid_i),
		.push_data_i(jtag_pkg::status_word_t'(stat_data_i)),
		.full_o(),
		.pop_i(stat_pop),
		.pop_data_o(stat_head),
		.empty_o(stat_empty),
		.credit_i(1'b0),
		.send_o()
	);

	// Status word holds the drop flag, a valid bit and the head word
	always_comb begin
		case (ctrl.instr)
			jtag_pkg::INSTR_IDCODE: cap_next = `JTAG_IDCODE;
			jtag_pkg::INSTR_ADDR: cap_next = 32'(dr.cur_addr);
			jtag_pkg::INSTR_DATA: cap_next = 32'(dr.shadow_rd);
			jtag_pkg::INSTR_STATUS: cap_next = {{(30 - `JTAG_DATA_W){1'b0}}, drop_sticky,
				!stat_empty, stat_empty ? {`JTAG_DATA_W{1'b0}} : stat_head.word};
			default: cap_next = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (ctrl.capture)
			cap_word <= cap_next;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			cap_load <= 1'b0;
			drop_sticky <= 1'b0;
			stat_credit_o <= 1'b0;
			tdo_o <= 1'b0;
		end else begin
			cap_load <= ctrl.capture;
			if (drop_i)
				drop_sticky <= 1'b1;
			else if (stat_pop)
				drop_sticky <= 1'b0;
			// Credit goes back only for a word actually taken
			stat_credit_o <= stat_pop && !stat_empty;
			if (ctrl.tck_fall)
				tdo_o <= ctrl.ir_shift ? ctrl.ir_tdo : dr.dr_tdo;
		end
	end

	assign dr.cap_word = cap_word;
	assign dr.cap_load = cap_load;
endmodule

/* rtl/dr_execute.sv */
`include "jtag_config.svh"

module dr_execute (
	input logic clk,
	input logic reset_i,
	tap_ctrl_if.sink ctrl,
	dr_data_if.execute dr,
	output logic cfg_valid_o,
	output logic [`JTAG_ADDR_W-1:0] cfg_addr_o,
	output logic [`JTAG_DATA_W-1:0] cfg_data_o,
	input logic cfg_credit_i,
	output logic drop_o
);
	localparam int REGS = 1 << `JTAG_ADDR_W;

	logic [31:0] dr_sr;
	logic [31:0] dr_shifted;
	logic [4:0] dr_msb;
	logic [`JTAG_ADDR_W-1:0] cur_addr;
	logic [`JTAG_DATA_W-1:0] shadow [REGS];
	logic data_update;
	logic q_full;
	logic q_send;
	jtag_pkg::cfg_write_t q_wr;
	jtag_pkg::cfg_write_t q_head;

	// Top bit of the selected data register
	always_comb begin
		case (ctrl.instr)
			jtag_pkg::INSTR_IDCODE: dr_msb = 5'd31;
			jtag_pkg::INSTR_STATUS: dr_msb = 5'd31;
			jtag_pkg::INSTR_ADDR: dr_msb = 5'(`JTAG_ADDR_W - 1);
			jtag_pkg::INSTR_DATA: dr_msb = 5'(`JTAG_DATA_W - 1);
			default: dr_msb = 5'd0;
		endcase
	end

	always_comb begin
		dr_shifted = {1'b0, dr_sr[31:1]};
		dr_shifted[dr_msb] = ctrl.tdi;
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			dr_sr <= '0;
		else if (dr.cap_load)
			dr_sr <= dr.cap_word;
		else if (ctrl.shift)
			dr_sr <= dr_shifted;
	end

	assign data_update = ctrl.update && (ctrl.instr == jtag_pkg::INSTR_DATA);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			cur_addr <= '0;
			shadow <= '{default: '0};
			drop_o <= 1'b0;
		end else begin
			if (ctrl.update && (ctrl.instr == jtag_pkg::INSTR_ADDR))
				cur_addr <= dr_sr[`JTAG_ADDR_W-1:0];
			if (data_update)
				shadow[cur_addr] <= dr_sr[`JTAG_DATA_W-1:0];
			// Shadow still takes the value when the write is lost
			drop_o <= data_update && q_full;
		end
	end

	assign q_wr.addr = cur_addr;
	assign q_wr.data = dr_sr[`JTAG_DATA_W-1:0];

	credit_fifo #(
		.payload_t(jtag_pkg::cfg_write_t),
		.DEPTH(`JTAG_CFG_CREDITS),
		.CREDITS(`JTAG_CFG_CREDITS)
	) i_cfg_fifo (
		.clk(clk),
		.reset_i(reset_i),
		.push_i(data_update && !q_full),
		.push_data_i(q_wr),
		.full_o(q_full),
		.pop_i(1'b0),
		.pop_data_o(q_head),
		.empty_o(),
		.credit_i(cfg_credit_i),
		.send_o(q_send)
	);

	always_ff @(posedge clk) begin
		if (reset_i)
			cfg_valid_o <= 1'b0;
		else
			cfg_valid_o <= q_send;
	end

	always_ff @(posedge clk) begin
		if (q_send) begin
			cfg_addr_o <= q_head.addr;
			cfg_data_o <= q_head.data;
		end
	end

	assign dr.dr_tdo = dr_sr[0];
	assign dr.cur_addr = cur_addr;
	assign dr.shadow_rd = shadow[cur_addr];
endmodule

/* rtl/tap_decode.sv */
`include "jtag_config.svh"

module tap_decode (
	input logic clk,
	input logic reset_i,
	input logic tck_i,
	input logic tms_i,
	input logic tdi_i,
	input logic trst_n_i,
	tap_ctrl_if.source ctrl
);
	logic [1:0] tck_sync;
	logic [1:0] tms_sync;
	logic [1:0] tdi_sync;
	logic [1:0] trst_sync;
	logic tck_prev;
	logic tck_rise;
	logic tck_fall;
	logic tms;
	jtag_pkg::tap_state_t state;
	jtag_pkg::tap_state_t state_next;
	logic [`JTAG_IR_W-1:0] ir_sr;
	logic [`JTAG_IR_W-1:0] ir_q;

	// Two-flop synchronizers for the oversampled pins
	always_ff @(posedge clk) begin
		if (reset_i) begin
			tck_sync <= '0;
			tms_sync <= '0;
			tdi_sync <= '0;
			trst_sync <= '0;
			tck_prev <= 1'b0;
		end else begin
			tck_sync <= {tck_sync[0], tck_i};
			tms_sync <= {tms_sync[0], tms_i};
			tdi_sync <= {tdi_sync[0], tdi_i};
			trst_sync <= {trst_sync[0], trst_n_i};
			tck_prev <= tck_sync[1];
		end
	end

	assign tck_rise = tck_sync[1] && !tck_prev;
	assign tck_fall = !tck_sync[1] && tck_prev;
	assign tms = tms_sync[1];

	always_comb begin
		state_next = state;
		case (state)
			jtag_pkg::TAP_TEST_LOGIC_RESET:
				state_next = tms ? jtag_pkg::TAP_TEST_LOGIC_RESET : jtag_pkg::TAP_RUN_TEST_IDLE;
			jtag_pkg::TAP_RUN_TEST_IDLE:
				state_next = tms ? jtag_pkg::TAP_SELECT_DR : jtag_pkg::TAP_RUN_TEST_IDLE;
			jtag_pkg::TAP_SELECT_DR:
				state_next = tms ? jtag_pkg::TAP_SELECT_IR : jtag_pkg::TAP_CAPTURE_DR;
			jtag_pkg::TAP_CAPTURE_DR:
				state_next = tms ? jtag_pkg::TAP_EXIT1_DR : jtag_pkg::TAP_SHIFT_DR;
			jtag_pkg::TAP_SHIFT_DR:
				state_next = tms ? jtag_pkg::TAP_EXIT1_DR : jtag_pkg::TAP_SHIFT_DR;
			jtag_pkg::TAP_EXIT1_DR:
				state_next = tms ? jtag_pkg::TAP_UPDATE_DR : jtag_pkg::TAP_PAUSE_DR;
			jtag_pkg::TAP_PAUSE_DR:
				state_next = tms ? jtag_pkg::TAP_EXIT2_DR : jtag_pkg::TAP_PAUSE_DR;
			jtag_pkg::TAP_EXIT2_DR:
				state_next = tms ? jtag_pkg::TAP_UPDATE_DR : jtag_pkg::TAP_SHIFT_DR;
			jtag_pkg::TAP_UPDATE_DR:
				state_next = tms ? jtag_pkg::TAP_SELECT_DR : jtag_pkg::TAP_RUN_TEST_IDLE;
			jtag_pkg::TAP_SELECT_IR:
				state_next = tms ? jtag_pkg::TAP_TEST_LOGIC_RESET : jtag_pkg::TAP_CAPTURE_IR;
			jtag_pkg::TAP_CAPTURE_IR:
				state_next = tms ? jtag_pkg::TAP_EXIT1_IR : jtag_pkg::TAP_SHIFT_IR;
			jtag_pkg::TAP_SHIFT_IR:
				state_next = tms ? jtag_pkg::TAP_EXIT1_IR : jtag_pkg::TAP_SHIFT_IR;
			jtag_pkg::TAP_EXIT1_IR:
				state_next = tms ? jtag_pkg::TAP_UPDATE_IR : jtag_pkg::TAP_PAUSE_IR;
			jtag_pkg::TAP_PAUSE_IR:
				state_next = tms ? jtag_pkg::TAP_EXIT2_IR : jtag_pkg::TAP_PAUSE_IR;
			jtag_pkg::TAP_EXIT2_IR:
				state_next = tms ? jtag_pkg::TAP_UPDATE_IR : jtag_pkg::TAP_SHIFT_IR;
			jtag_pkg::TAP_UPDATE_IR:
				state_next = tms ? jtag_pkg::TAP_SELECT_DR : jtag_pkg::TAP_RUN_TEST_IDLE;
			default: state_next = jtag_pkg::TAP_TEST_LOGIC_RESET;
		endcase
	end

	// TRST acts as a synchronous jump to Test-Logic-Reset
	always_ff @(posedge clk) begin
		if (reset_i || !trst_sync[1])
			state <= jtag_pkg::TAP_TEST_LOGIC_RESET;
		else if (tck_rise)
			state <= state_next;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ir_sr <= '0;
			ir_q <= `JTAG_IR_IDCODE;
		end else if (state == jtag_pkg::TAP_TEST_LOGIC_RESET) begin
			ir_q <= `JTAG_IR_IDCODE;
		end else if (tck_rise) begin
			case (state)
				jtag_pkg::TAP_CAPTURE_IR: ir_sr <= `JTAG_IR_W'(1);
				jtag_pkg::TAP_SHIFT_IR: ir_sr <= {tdi_sync[1], ir_sr[`JTAG_IR_W-1:1]};
				jtag_pkg::TAP_UPDATE_IR: ir_q <= ir_sr;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (ir_q)
			`JTAG_IR_IDCODE: ctrl.instr = jtag_pkg::INSTR_IDCODE;
			`JTAG_IR_ADDR: ctrl.instr = jtag_pkg::INSTR_ADDR;
			`JTAG_IR_DATA: ctrl.instr = jtag_pkg::INSTR_DATA;
			`JTAG_IR_STATUS: ctrl.instr = jtag_pkg::INSTR_STATUS;
			`JTAG_IR_BYPASS: ctrl.instr = jtag_pkg::INSTR_BYPASS;
			default: ctrl.instr = jtag_pkg::INSTR_BYPASS;
		endcase
	end

	assign ctrl.capture = tck_rise && (state == jtag_pkg::TAP_CAPTURE_DR);
	assign ctrl.shift = tck_rise && (state == jtag_pkg::TAP_SHIFT_DR);
	assign ctrl.update = tck_rise && (state == jtag_pkg::TAP_UPDATE_DR);
	assign ctrl.tdi = tdi_sync[1];
	assign ctrl.tck_fall = tck_fall;
	assign ctrl.ir_shift = state == jtag_pkg::TAP_SHIFT_IR;
	assign ctrl.ir_tdo = ir_sr[0];

	// Oversampling needs each TCK level held for 4 clk or more
	a_tck_hold: assert property (@(posedge clk) disable iff (reset_i)
		(tck_rise || tck_fall) |=> !(tck_rise || tck_fall) [*3])
		else $error("TCK level held for fewer than 4 clk");
endmodule

/* rtl/credit_fifo.sv */
module credit_fifo #(
	parameter type payload_t = logic,
	parameter int DEPTH = 4,
	parameter int CREDITS = 0
) (
	input logic clk,
	input logic reset_i,
	input logic push_i,
	input payload_t push_data_i,
	output logic full_o,
	input logic pop_i,
	output payload_t pop_data_o,
	output logic empty_o,
	input logic credit_i,
	output logic send_o
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int FW = $clog2(DEPTH + 1);
	localparam int CW = (CREDITS > 0) ? $clog2(CREDITS + 1) : 1;

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [FW-1:0] fill;
	logic [CW-1:0] credit_cnt;
	logic do_push;
	logic do_pop;

	assign full_o = fill == FW'(DEPTH);
	assign empty_o = fill == '0;
	assign pop_data_o = mem[rd_ptr];

	// Credit mode drains the head on its own, plain mode waits for pop_i
	assign send_o = (CREDITS != 0) && !empty_o && (credit_cnt != '0);
	assign do_pop = (CREDITS != 0) ? send_o : (pop_i && !empty_o);
	assign do_push = push_i && !full_o;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data_i;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			credit_cnt <= CW'(CREDITS);
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			fill <= fill + FW'(do_push) - FW'(do_pop);
			credit_cnt <= credit_cnt + CW'(credit_i) - CW'(send_o);
		end
	end

	// Receiver never returns more than it was given
	a_credit_max: assert property (@(posedge clk) disable iff (reset_i)
		credit_cnt <= CW'(CREDITS))
		else $error("credit count above %0d", CREDITS);

	a_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
		push_i |-> !full_o)
		else $error("push into full queue");
endmodule

/* rtl/jtag_intf.sv */
`include "jtag_config.svh"

interface tap_ctrl_if;
	// DR pulses last one clk each
	logic capture;
	logic shift;
	logic update;
	jtag_pkg::instr_t instr;
	logic tdi;
	logic tck_fall;
	logic ir_shift;
	logic ir_tdo;

	modport source (output capture, shift, update, instr, tdi, tck_fall, ir_shift, ir_tdo);
	modport sink (input capture, shift, update, instr, tdi, tck_fall, ir_shift, ir_tdo);
endinterface

interface dr_data_if;
	logic [31:0] cap_word;
	logic cap_load;
	logic dr_tdo;
	logic [`JTAG_ADDR_W-1:0] cur_addr;
	logic [`JTAG_DATA_W-1:0] shadow_rd;

	modport execute (input cap_word, cap_load, output dr_tdo, cur_addr, shadow_rd);
	modport result (output cap_word, cap_load, input dr_tdo, cur_addr, shadow_rd);
endinterface

/* rtl/jtag_pkg.sv */
`include "jtag_config.svh"

package jtag_pkg;

	typedef enum logic [3:0] {
		TAP_TEST_LOGIC_RESET,
		TAP_RUN_TEST_IDLE,
		TAP_SELECT_DR,
		TAP_CAPTURE_DR,
		TAP_SHIFT_DR,
		TAP_EXIT1_DR,
		TAP_PAUSE_DR,
		TAP_EXIT2_DR,
		TAP_UPDATE_DR,
		TAP_SELECT_IR,
		TAP_CAPTURE_IR,
		TAP_SHIFT_IR,
		TAP_EXIT1_IR,
		TAP_PAUSE_IR,
		TAP_EXIT2_IR,
		TAP_UPDATE_IR
	} tap_state_t;

	// Undefined IR codes decode to bypass
	typedef enum logic [2:0] {
		INSTR_IDCODE,
		INSTR_ADDR,
		INSTR_DATA,
		INSTR_STATUS,
		INSTR_BYPASS
	} instr_t;

	typedef struct packed {
		logic [`JTAG_ADDR_W-1:0] addr;
		logic [`JTAG_DATA_W-1:0] data;
	} cfg_write_t;

	typedef struct packed {
		logic [`JTAG_DATA_W-1:0] word;
	} status_word_t;

endpackage

/* rtl/jtag_config.svh */
`ifndef JTAG_CONFIG_SVH
`define JTAG_CONFIG_SVH

// Register and word widths
`define JTAG_IR_W 4
`define JTAG_ADDR_W 4
`define JTAG_DATA_W 16

// Version 1, part 0x071c, manufacturer 0x051, bit 0 set
`define JTAG_IDCODE 32'h1071_c0a3

`define JTAG_CFG_CREDITS 4
`define JTAG_STAT_DEPTH 4

`define JTAG_IR_IDCODE 4'd1
`define JTAG_IR_ADDR 4'd2
`define JTAG_IR_DATA 4'd3
`define JTAG_IR_STATUS 4'd4
`define JTAG_IR_BYPASS 4'd15
`endif
